//--- logic/fir_defs.svh
`ifndef FIR_DEFS_SVH
`define FIR_DEFS_SVH

// sample and coefficient width
`define FIR_DATA_W 32

// register port address width
`define FIR_ADDR_W 12

// number of filter taps
`define FIR_TAPS 11

// register map
`define FIR_ADDR_AP   12'h000
`define FIR_ADDR_LEN  12'h010
// coefficients follow 4 bytes apart, tap 10 at 0x48
`define FIR_ADDR_TAP0 12'h020

`endif

//--- logic/fir_pkg.sv
`default_nettype none

`include "fir_defs.svh"

package fir_pkg;

    // samples, coefficients, products and sums
    typedef logic signed [`FIR_DATA_W-1:0] data_t;

    // tap number or sample distance, 0 to 10
    typedef logic [3:0] tap_idx_t;

    // control word bit fields
    typedef struct packed {
        logic [`FIR_DATA_W-4:0] reserved;
        logic                   idle;
        logic                   done;
        logic                   start;
    } ap_fields_t;

    // control word seen as a raw bus word or as its fields
    typedef union packed {
        data_t      raw;
        ap_fields_t fields;
    } ap_word_u;

    typedef enum logic [1:0] {
        st_idle,
        st_take,
        st_mac,
        st_give
    } fir_state_e;

endpackage

`default_nettype wire

//--- logic/fir_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_defs.svh"

module fir_ctrl (
    input  wire              axis_clk,
    input  wire              axis_rst_n,
    input  wire              start_pulse,
    input  wire fir_pkg::data_t length,
    input  wire              ss_tvalid,
    input  wire              sm_tvalid,
    input  wire              sm_tready,
    output logic             busy,
    output logic             done_pulse,
    output logic             ss_tready,
    output logic             ring_clear,
    output logic             ring_push,
    output fir_pkg::tap_idx_t tap_idx,
    output logic             acc_clear,
    output logic             acc_en,
    output logic             out_load,
    output logic             out_last
);

    localparam fir_pkg::tap_idx_t LAST_TAP = 4'(`FIR_TAPS - 1);

    fir_pkg::fir_state_e    state;
    fir_pkg::fir_state_e    state_nx;
    fir_pkg::tap_idx_t      tap_cnt;
    // number of the output currently being produced, 1-based
    logic [`FIR_DATA_W-1:0] out_num;
    logic                   take_fire;
    logic                   give_fire;

    assign busy      = (state != fir_pkg::st_idle);
    assign ss_tready = (state == fir_pkg::st_take);
    assign take_fire = ss_tready && ss_tvalid;
    assign give_fire = (state == fir_pkg::st_give) && sm_tvalid && sm_tready;

    // ring starts from zeros on every run
    assign ring_clear = (state == fir_pkg::st_idle) && start_pulse;
    assign ring_push  = take_fire;
    assign acc_clear  = take_fire;
    assign acc_en     = (state == fir_pkg::st_mac);
    assign tap_idx    = tap_cnt;

    // load once on entry to st_give, then hold until accepted
    assign out_load   = (state == fir_pkg::st_give) && !sm_tvalid;
    assign out_last   = (out_num == length);
    assign done_pulse = give_fire && out_last;

    always_comb begin
        state_nx = state;
        case (state)
            fir_pkg::st_idle: begin
                if (start_pulse) begin
                    state_nx = fir_pkg::st_take;
                end
            end
            fir_pkg::st_take: begin
                if (take_fire) begin
                    state_nx = fir_pkg::st_mac;
                end
            end
            fir_pkg::st_mac: begin
                if (tap_cnt == LAST_TAP) begin
                    state_nx = fir_pkg::st_give;
                end
            end
            fir_pkg::st_give: begin
                if (give_fire) begin
                    state_nx = out_last ? fir_pkg::st_idle : fir_pkg::st_take;
                end
            end
            default: state_nx = fir_pkg::st_idle;
        endcase
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            state   <= fir_pkg::st_idle;
            tap_cnt <= '0;
            out_num <= '0;
        end else begin
            state <= state_nx;
            // tap counter rewinds after tap 10
            if (acc_en) begin
                tap_cnt <= (tap_cnt == LAST_TAP) ? '0 : tap_cnt + 1'b1;
            end
            if (ring_clear) begin
                out_num <= 1;
            end else if (give_fire) begin
                out_num <= out_num + 1'b1;
            end
        end
    end

    // input and output never open together, one sample in flight
    a_one_in_flight: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        !(ss_tready && sm_tvalid));

    a_tap_range: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        tap_idx < `FIR_TAPS);

endmodule

`default_nettype wire

//--- logic/fir_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_defs.svh"

module fir_cfg_regs (
    input  wire                    axis_clk,
    input  wire                    axis_rst_n,
    input  wire                    awvalid,
    input  wire [`FIR_ADDR_W-1:0]  awaddr,
    input  wire                    wvalid,
    input  wire [`FIR_DATA_W-1:0]  wdata,
    input  wire                    arvalid,
    input  wire [`FIR_ADDR_W-1:0]  araddr,
    input  wire                    rready,
    input  wire                    busy,
    input  wire                    done_pulse,
    input  wire fir_pkg::data_t    host_coef,
    output logic                   awready,
    output logic                   wready,
    output logic                   arready,
    output logic                   rvalid,
    output logic [`FIR_DATA_W-1:0] rdata,
    output logic                   start_pulse,
    output fir_pkg::data_t         length,
    output logic                   host_we,
    output fir_pkg::tap_idx_t      host_idx,
    output fir_pkg::data_t         host_wdata
);

    fir_pkg::ap_word_u      ap_wr;
    fir_pkg::ap_word_u      ap_q;
    fir_pkg::ap_word_u      ap_rd;
    fir_pkg::tap_idx_t      aw_idx;
    fir_pkg::tap_idx_t      ar_idx;
    logic                   wr_fire;
    logic                   rd_fire;
    logic                   ar_is_tap;
    logic                   ap_start_wr;
    logic [`FIR_DATA_W-1:0] rd_value;

    function automatic logic addr_is_tap(input logic [`FIR_ADDR_W-1:0] addr);
        return (addr >= `FIR_ADDR_TAP0) && (addr <= `FIR_ADDR_TAP0 + 4 * (`FIR_TAPS - 1))
            && (addr[1:0] == 2'b00);
    endfunction

    function automatic fir_pkg::tap_idx_t addr_to_idx(input logic [`FIR_ADDR_W-1:0] addr);
        logic [`FIR_ADDR_W-1:0] offs;
        offs = addr - `FIR_ADDR_TAP0;
        return fir_pkg::tap_idx_t'(offs >> 2);
    endfunction

    // address and data must arrive together
    assign wr_fire = awvalid && wvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;

    assign ap_wr.raw   = wdata;
    assign ap_start_wr = wr_fire && (awaddr == `FIR_ADDR_AP) && ap_wr.fields.start
                         && !busy && !ap_q.fields.start;

    // coefficient store, host writes win the shared index
    assign aw_idx     = addr_to_idx(awaddr);
    assign ar_idx     = addr_to_idx(araddr);
    assign ar_is_tap  = addr_is_tap(araddr);
    assign host_we    = wr_fire && addr_is_tap(awaddr) && !busy;
    assign host_idx   = host_we ? aw_idx : ar_idx;
    assign host_wdata = wdata;

    always_comb begin
        ap_rd             = ap_q;
        ap_rd.fields.idle = !busy;
    end

    always_comb begin
        if (araddr == `FIR_ADDR_AP) begin
            rd_value = ap_rd.raw;
        end else if (araddr == `FIR_ADDR_LEN) begin
            rd_value = length;
        end else if (ar_is_tap) begin
            rd_value = host_coef;
        end else begin
            rd_value = '0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            ap_q.raw    <= '0;
            start_pulse <= 1'b0;
            length      <= '0;
        end else begin
            start_pulse <= ap_start_wr;
            if (ap_start_wr) begin
                ap_q.fields.start <= 1'b1;
                ap_q.fields.done  <= 1'b0;
            end else begin
                // start drops as the controller leaves idle
                if (start_pulse) begin
                    ap_q.fields.start <= 1'b0;
                end
                if (done_pulse) begin
                    ap_q.fields.done <= 1'b1;
                end
            end
            if (wr_fire && (awaddr == `FIR_ADDR_LEN) && !busy) begin
                length <= wdata;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rd_fire) begin
            rdata <= rd_value;
        end
    end

    a_read_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

//--- logic/fir_tap_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_defs.svh"

module fir_tap_ram (
    input  wire                    axis_clk,
    input  wire                    host_we,
    input  wire fir_pkg::tap_idx_t host_idx,
    input  wire fir_pkg::data_t    host_wdata,
    input  wire fir_pkg::tap_idx_t tap_idx,
    output fir_pkg::data_t         host_coef,
    output fir_pkg::data_t         tap_coef
);

    fir_pkg::data_t coef_mem [`FIR_TAPS];

    // host side, write and read back
    always_ff @(posedge axis_clk) begin
        if (host_we) begin
            coef_mem[host_idx] <= host_wdata;
        end
    end

    assign host_coef = coef_mem[host_idx];

    // multiplier side, read only
    assign tap_coef = coef_mem[tap_idx];

endmodule

`default_nettype wire

//--- logic/fir_sample_ring.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_defs.svh"

module fir_sample_ring (
    input  wire                    axis_clk,
    input  wire                    axis_rst_n,
    input  wire                    ring_clear,
    input  wire                    ring_push,
    input  wire fir_pkg::data_t    ss_tdata,
    input  wire fir_pkg::tap_idx_t tap_idx,
    output fir_pkg::data_t         ring_sample
);

    localparam fir_pkg::tap_idx_t LAST_SLOT = 4'(`FIR_TAPS - 1);

    fir_pkg::data_t    ring [`FIR_TAPS];
    // slot of the newest sample
    fir_pkg::tap_idx_t head;
    fir_pkg::tap_idx_t head_nx;
    fir_pkg::tap_idx_t rd_ptr;

    assign head_nx = (head == LAST_SLOT) ? '0 : head + 1'b1;

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            head <= '0;
        end else if (ring_clear) begin
            head <= '0;
        end else if (ring_push) begin
            head <= head_nx;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (ring_clear) begin
            for (int i = 0; i < `FIR_TAPS; i++) begin
                ring[i] <= '0;
            end
        end else if (ring_push) begin
            ring[head_nx] <= ss_tdata;
        end
    end

    // head minus distance, modulo the tap count
    // the 4-bit wrap of head + 11 - idx lands on the right slot
    always_comb begin
        if (head >= tap_idx) begin
            rd_ptr = head - tap_idx;
        end else begin
            rd_ptr = head + 4'(`FIR_TAPS) - tap_idx;
        end
    end

    assign ring_sample = ring[rd_ptr];

endmodule

`default_nettype wire

//--- logic/fir_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_defs.svh"

module fir_mac (
    input  wire                 axis_clk,
    input  wire                 axis_rst_n,
    input  wire                 acc_clear,
    input  wire                 acc_en,
    input  wire fir_pkg::data_t tap_coef,
    input  wire fir_pkg::data_t ring_sample,
    input  wire                 out_load,
    input  wire                 out_last,
    input  wire                 sm_tready,
    output logic                sm_tvalid,
    output fir_pkg::data_t      sm_tdata,
    output logic                sm_tlast
);

    fir_pkg::data_t acc;
    fir_pkg::data_t product;

    // low 32 bits of the signed product, wraps like the sum
    assign product = tap_coef * ring_sample;

    always_ff @(posedge axis_clk) begin
        if (acc_clear) begin
            acc <= '0;
        end else if (acc_en) begin
            acc <= acc + product;
        end
    end

    // output register, held until the sink takes it
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end else if (out_load) begin
            sm_tvalid <= 1'b1;
            sm_tlast  <= out_last;
        end else if (sm_tvalid && sm_tready) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (out_load) begin
            sm_tdata <= acc;
        end
    end

    a_out_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast));

endmodule

`default_nettype wire

//--- logic/fir_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_defs.svh"

module fir_top (
    input  wire                   axis_clk,
    input  wire                   axis_rst_n,
    input  wire                   awvalid,
    input  wire [`FIR_ADDR_W-1:0] awaddr,
    input  wire                   wvalid,
    input  wire [`FIR_DATA_W-1:0] wdata,
    output wire                   awready,
    output wire                   wready,
    input  wire                   arvalid,
    input  wire [`FIR_ADDR_W-1:0] araddr,
    input  wire                   rready,
    output wire                   arready,
    output wire                   rvalid,
    output wire [`FIR_DATA_W-1:0] rdata,
    input  wire                   ss_tvalid,
    input  wire fir_pkg::data_t   ss_tdata,
    output wire                   ss_tready,
    input  wire                   sm_tready,
    output wire                   sm_tvalid,
    output wire fir_pkg::data_t   sm_tdata,
    output wire                   sm_tlast
);

    wire                    start_pulse;
    wire                    done_pulse;
    wire                    busy;
    wire fir_pkg::data_t    length;
    wire                    host_we;
    wire fir_pkg::tap_idx_t host_idx;
    wire fir_pkg::data_t    host_wdata;
    wire fir_pkg::data_t    host_coef;
    wire                    ring_clear;
    wire                    ring_push;
    wire fir_pkg::tap_idx_t tap_idx;
    wire                    acc_clear;
    wire                    acc_en;
    wire                    out_load;
    wire                    out_last;
    wire fir_pkg::data_t    tap_coef;
    wire fir_pkg::data_t    ring_sample;

    fir_cfg_regs u_cfg_regs (
        .axis_clk, .axis_rst_n,
        .awvalid, .awaddr, .wvalid, .wdata, .awready, .wready,
        .arvalid, .araddr, .rready, .arready, .rvalid, .rdata,
        .busy, .done_pulse, .host_coef,
        .start_pulse, .length, .host_we, .host_idx, .host_wdata
    );

    fir_ctrl u_ctrl (
        .axis_clk, .axis_rst_n,
        .start_pulse, .length, .ss_tvalid, .sm_tvalid, .sm_tready,
        .busy, .done_pulse, .ss_tready, .ring_clear, .ring_push,
        .tap_idx, .acc_clear, .acc_en, .out_load, .out_last
    );

    fir_tap_ram u_tap_ram (
        .axis_clk, .host_we, .host_idx, .host_wdata, .tap_idx,
        .host_coef, .tap_coef
    );

    fir_sample_ring u_sample_ring (
        .axis_clk, .axis_rst_n, .ring_clear, .ring_push, .ss_tdata,
        .tap_idx, .ring_sample
    );

    fir_mac u_mac (
        .axis_clk, .axis_rst_n, .acc_clear, .acc_en, .tap_coef, .ring_sample,
        .out_load, .out_last, .sm_tready, .sm_tvalid, .sm_tdata, .sm_tlast
    );

endmodule

`default_nettype wire

//--- bench/fir_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_defs.svh"

module fir_tb;

    localparam int NUM_ROWS = 4;

    logic                   axis_clk;
    logic                   axis_rst_n;
    logic                   awvalid;
    logic [`FIR_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    logic [`FIR_DATA_W-1:0] wdata;
    logic                   arvalid;
    logic [`FIR_ADDR_W-1:0] araddr;
    logic                   rready;
    logic                   ss_tvalid;
    fir_pkg::data_t         ss_tdata;
    logic                   sm_tready;
    wire                    awready;
    wire                    wready;
    wire                    arready;
    wire                    rvalid;
    wire [`FIR_DATA_W-1:0]  rdata;
    wire                    ss_tready;
    wire                    sm_tvalid;
    wire fir_pkg::data_t    sm_tdata;
    wire                    sm_tlast;

    // per row: eleven coefficients, output count, output stall flag, input gap flag
    fir_pkg::data_t tbl_coef [NUM_ROWS][`FIR_TAPS] = '{
        '{1, 2, 3, 4, 5, 6, 5, 4, 3, 2, 1},
        '{-3, 7, 0, -1, 12, 100, -100, 9, 0, 4, -2},
        '{32'h7fff_ffff, 32'h8000_0001, 65537, -65536, 3, 32'h0001_0000,
          -1, 2, 32'h4000_0000, 5, 32'hffff_fff0},
        '{0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0}
    };
    int             tbl_len   [NUM_ROWS] = '{5, 30, 17, 1};
    bit             tbl_stall [NUM_ROWS] = '{1'b0, 1'b1, 1'b1, 1'b0};
    bit             tbl_gap   [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b1};

    logic [31:0]    seed;
    int             data_errs;
    int             ap_errs;
    int             bit_errs;
    int             cycle_count;
    int             cycle_limit;
    // samples of the current run, oldest first
    fir_pkg::data_t hist [$];

    fir_top UUT (.*);

    initial begin
        axis_clk = 1'b0;
        forever #10 axis_clk = ~axis_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int run_budget();
        int total;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += 40 * tbl_len[r] + 200;
        end
        return total;
    endfunction

    function automatic logic [`FIR_ADDR_W-1:0] tap_addr(input int k);
        return `FIR_ADDR_W'(`FIR_ADDR_TAP0 + 4 * k);
    endfunction

    // coefficient k times the sample k places older, zeros before the start
    function automatic fir_pkg::data_t fir_expect(input int row);
        longint sum;
        int     n;
        sum = 0;
        n = hist.size() - 1;
        for (int k = 0; k < `FIR_TAPS; k++) begin
            if (n - k >= 0) begin
                sum += longint'(tbl_coef[row][k]) * longint'(hist[n - k]);
            end
        end
        return fir_pkg::data_t'(sum[31:0]);
    endfunction

    function automatic fir_pkg::ap_fields_t ap_expect(input logic idle, input logic done,
                                                      input logic start);
        fir_pkg::ap_fields_t f;
        f = '0;
        f.idle  = idle;
        f.done  = done;
        f.start = start;
        return f;
    endfunction

    task automatic check_data(input string name, input fir_pkg::data_t got,
                              input fir_pkg::data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("** Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_ap(input string name, input fir_pkg::ap_fields_t got,
                            input fir_pkg::ap_fields_t exp);
        if (got !== exp) begin
            ap_errs++;
            $display("** Error at %0t: %s got %h (idle %b done %b start %b) expected %h",
                     $time, name, got, got.idle, got.done, got.start, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            bit_errs++;
            $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // one clock, then on to the drive point just after the edge
    task automatic next_cycle();
        @(posedge axis_clk);
        #2;
    endtask

    task automatic reg_write(input logic [`FIR_ADDR_W-1:0] addr,
                             input logic [`FIR_DATA_W-1:0] value);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = value;
        next_cycle();
        check_bit("awready", awready, 1'b1);
        check_bit("wready", wready, 1'b1);
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic reg_read(input logic [`FIR_ADDR_W-1:0] addr,
                            output logic [`FIR_DATA_W-1:0] value);
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b0;
        check_bit("arready", arready, 1'b1);
        next_cycle();
        arvalid = 1'b0;
        check_bit("rvalid", rvalid, 1'b1);
        check_bit("arready while rvalid", arready, 1'b0);
        // sink holds off for one cycle, the response has to wait
        next_cycle();
        check_bit("rvalid while held", rvalid, 1'b1);
        value  = rdata;
        rready = 1'b1;
        next_cycle();
        rready = 1'b0;
        check_bit("rvalid after accept", rvalid, 1'b0);
    endtask

    task automatic expect_reg(input string name, input logic [`FIR_ADDR_W-1:0] addr,
                              input fir_pkg::data_t exp);
        logic [`FIR_DATA_W-1:0] value;
        reg_read(addr, value);
        check_data(name, fir_pkg::data_t'(value), exp);
    endtask

    task automatic expect_ap(input string name, input logic idle, input logic done,
                             input logic start);
        logic [`FIR_DATA_W-1:0] value;
        fir_pkg::ap_word_u      word;
        reg_read(`FIR_ADDR_AP, value);
        word.raw = fir_pkg::data_t'(value);
        check_ap(name, word.fields, ap_expect(idle, done, start));
    endtask

    task automatic run_row(input int row);
        fir_pkg::data_t exp;
        int             lat;
        int             wait_n;
        logic           last;
        for (int k = 0; k < `FIR_TAPS; k++) begin
            reg_write(tap_addr(k), tbl_coef[row][k]);
        end
        reg_write(`FIR_ADDR_LEN, tbl_len[row]);
        for (int k = 0; k < `FIR_TAPS; k++) begin
            expect_reg("coefficient readback", tap_addr(k), tbl_coef[row][k]);
        end
        expect_reg("length readback", `FIR_ADDR_LEN, tbl_len[row]);
        reg_write(`FIR_ADDR_AP, 32'h1);
        while (!ss_tready) next_cycle();
        // controller has left idle, the store is locked now
        reg_write(tap_addr(3), 32'hdead_beef);
        expect_ap("control word while busy", 1'b0, 1'b0, 1'b0);
        expect_reg("coefficient 3 after busy write", tap_addr(3), tbl_coef[row][3]);
        hist.delete();
        for (int n = 0; n < tbl_len[row]; n++) begin
            last = (n == tbl_len[row] - 1);
            if (tbl_gap[row]) begin
                seed = lcg_next(seed);
                repeat (seed[29:28]) next_cycle();
            end
            seed      = lcg_next(seed);
            ss_tdata  = fir_pkg::data_t'(seed);
            ss_tvalid = 1'b1;
            while (!ss_tready) next_cycle();
            next_cycle();
            ss_tvalid = 1'b0;
            hist.push_back(ss_tdata);
            exp = fir_expect(row);
            lat = 0;
            while (!sm_tvalid) begin
                next_cycle();
                lat++;
            end
            check_data("sm_tvalid latency", fir_pkg::data_t'(lat), 12);
            check_data("sm_tdata", sm_tdata, exp);
            check_bit("sm_tlast", sm_tlast, last);
            wait_n = 0;
            if (tbl_stall[row]) begin
                seed   = lcg_next(seed);
                wait_n = int'(seed[30:28]);
            end
            repeat (wait_n) begin
                next_cycle();
                check_bit("sm_tvalid while stalled", sm_tvalid, 1'b1);
                check_data("sm_tdata while stalled", sm_tdata, exp);
                check_bit("sm_tlast while stalled", sm_tlast, last);
            end
            sm_tready = 1'b1;
            next_cycle();
            sm_tready = 1'b0;
            check_bit("sm_tvalid after accept", sm_tvalid, 1'b0);
            check_bit("ss_tready after accept", ss_tready, !last);
        end
        expect_ap("control word after run", 1'b1, 1'b1, 1'b0);
    endtask

    // watchdog
    initial begin
        fir_pkg::fir_state_e st;
        cycle_limit = run_budget();
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge axis_clk);
            cycle_count++;
        end
        st = UUT.u_ctrl.state;
        $display("timeout: the run did not finish within %0d cycles, controller in %s",
                 cycle_count, st.name());
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        seed       = 32'h74a7;
        repeat (3) @(posedge axis_clk);
        #2;
        axis_rst_n = 1'b1;
        expect_ap("control word after reset", 1'b1, 1'b0, 1'b0);
        expect_reg("unmapped 0x004", 12'h004, 0);
        expect_reg("unmapped 0x04c", 12'h04c, 0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("errors: data %0d, control word %0d, flags %0d", data_errs, ap_errs,
                 bit_errs);
        if (data_errs + ap_errs + bit_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+logic
logic/fir_pkg.sv
logic/fir_ctrl.sv
logic/fir_cfg_regs.sv
logic/fir_tap_ram.sv
logic/fir_sample_ring.sv
logic/fir_mac.sv
logic/fir_top.sv
bench/fir_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the FIR testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module fir_tb -o fir_sim \
    && ./obj_dir/fir_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "TESTS PASSED" sim.log && exit 0 || exit 1
